// ==== branch_cond.sv ====
module branch_cond import ctl_pkg::*; (
  input  logic [3:0] cond,
  input  ccr_t       ccr,
  output logic       taken
);

  logic n_xor_v;  // signed less than

  assign n_xor_v = ccr.negative ^ ccr.overflow;

  always_comb begin
    case (cond)
      cc_always: taken = 1'b1;
      cc_eq:     taken = ccr.zero;
      cc_ne:     taken = ~ccr.zero;
      cc_gtu:    taken = ~(ccr.zero | ccr.carry);
      cc_gt:     taken = ~(ccr.zero | n_xor_v);
      cc_ge:     taken = ~n_xor_v;
      cc_le:     taken = ccr.zero | n_xor_v;
      cc_lt:     taken = n_xor_v;
      cc_geu:    taken = ~ccr.carry;
      cc_ltu:    taken = ccr.carry;
      cc_leu:    taken = ccr.carry | ccr.zero;
      cc_never:  taken = 1'b0;
      default:   taken = 1'b0;  // codes 0xc up are never decoded as branches
    endcase
  end

endmodule

// ==== byte_lane_gen.sv ====
module byte_lane_gen import ctl_pkg::*; (
  input  access_size_t size,
  input  logic [1:0]   bus_align,
  output lanes_t       lanes
);

  // big endian lane order
  always_comb begin
    case (size)
      size_half: begin
        lanes = bus_align[1] ? 4'b0011 : 4'b1100;
      end
      size_byte: begin
        lanes = 4'b1000 >> bus_align;  // lane 3 at offset 0
      end
      default: begin
        lanes = 4'b1111;
      end
    endcase
  end

endmodule

// ==== control.sv ====
module control import ctl_pkg::*; (
  input  logic       clock,
  input  logic       reset_n,
  input  word_t      ir,
  input  ccr_t       ccr,
  input  logic       bus_wait,
  input  logic       busfault,
  input  logic [1:0] bus_align,  // low address bits of the current access
  output dp_ctl_t    dp,
  output reg_ports_t regs,
  output bus_ctl_t   bus,
  output logic       halt
);

  ir_fields_t fields;
  decoded_t   decoded;
  logic       taken;
  lanes_t     lanes;

  ir_decoder u_decoder (
    .ir      (ir),
    .fields  (fields),
    .decoded (decoded)
  );

  branch_cond u_branch_cond (
    .cond  (decoded.cond),
    .ccr   (ccr),
    .taken (taken)
  );

  byte_lane_gen u_lanes (
    .size      (decoded.size),
    .bus_align (bus_align),
    .lanes     (lanes)
  );

  micro_sequencer u_sequencer (
    .clock    (clock),
    .reset_n  (reset_n),
    .fields   (fields),
    .decoded  (decoded),
    .taken    (taken),
    .lanes    (lanes),
    .bus_wait (bus_wait),
    .busfault (busfault),
    .dp       (dp),
    .regs     (regs),
    .bus      (bus),
    .halt     (halt)
  );

endmodule

// ==== control_golden.txt ====
# ir ccr align wait fault | expected: reg_writes pcsel byteenable ccr_write halt eval_cycles
# all values hex, wait and fault apply to the bus step of the evaluation
0A0110C0 0 0 0 0 0 0 f 0 0 1
004110C0 0 0 0 0 0 0 f 1 0 1
006110C0 0 0 0 0 1 0 f 0 0 2
008110C0 0 0 0 0 1 0 f 0 0 2
00E110C0 0 0 0 0 1 0 f 0 0 1
012110C0 0 0 0 0 1 0 f 0 0 1
02E110C0 0 0 0 0 1 0 f 0 0 1
044110C0 0 0 0 0 1 0 f 0 0 2
400110C0 0 0 0 0 0 3 f 0 0 1
402110C0 1 0 0 0 0 3 f 0 0 1
402110C0 0 0 0 0 0 0 f 0 0 1
406110C0 0 0 0 0 0 3 f 0 0 1
406110C0 8 0 0 0 0 0 f 0 0 1
40E110C0 4 0 0 0 0 3 f 0 0 1
40E110C0 6 0 0 0 0 0 f 0 0 1
416110C0 f 0 0 0 0 0 f 0 0 1
41A110C0 0 0 0 0 1 0 f 0 0 1
214110C0 0 0 0 0 1 0 f 0 0 2
216110C0 0 0 0 0 0 4 f 0 0 2
200110C0 0 0 2 0 0 0 f 0 0 6
202110C0 0 0 0 0 1 0 f 0 0 4
206110C0 0 0 1 0 1 0 c 0 0 5
204110C0 0 2 0 0 0 0 3 0 0 4
20A110C0 0 1 0 0 1 0 4 0 0 4
20A110C0 0 3 3 0 1 0 1 0 0 7
208110C0 0 0 0 0 0 0 8 0 0 4
202110C0 0 0 0 1 0 5 f 0 1 4
002110C0 0 0 0 0 0 0 f 0 1 1

// ==== control_properties.sv ====
module control_properties import ctl_pkg::*; (
  input logic     clock,
  input logic     reset_n,
  input logic     bus_wait,
  input logic     busfault,
  input dp_ctl_t  dp,
  input bus_ctl_t bus,
  input logic     halt
);

  logic fetch_read;  // fetch step 0, the plain instruction read

  assign fetch_read = bus.read && !dp.ir_write && dp.addrsel == addr_pc &&
                      dp.marsel == mar_hold && dp.pcsel == pc_hold;

  read_write_excl: assert property (@(posedge clock) disable iff (!reset_n)
    !(bus.read && bus.write)) else $error("bus read and write high together");

  halt_sticky: assert property (@(posedge clock) disable iff (!reset_n)
    halt |=> halt) else $error("halt dropped without reset");

  ir_after_read: assert property (@(posedge clock) disable iff (!reset_n)
    (fetch_read && !bus_wait && !busfault) |=> dp.ir_write)
    else $error("ir_write missing after completed fetch read");

  ir_only_after_read: assert property (@(posedge clock) disable iff (!reset_n)
    dp.ir_write |-> $past(fetch_read && !bus_wait))
    else $error("ir_write without a completed fetch read");

endmodule

bind control control_properties u_props (
  .clock    (clock),
  .reset_n  (reset_n),
  .bus_wait (bus_wait),
  .busfault (busfault),
  .dp       (dp),
  .bus      (bus),
  .halt     (halt)
);

// ==== ctl_pkg.sv ====
package ctl_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  opcode_t;
  typedef logic [3:0]  lanes_t;
  typedef logic [2:0]  seq_t;

  typedef enum logic [2:0] {
    mode_reg    = 3'h0,
    mode_regind = 3'h1,
    mode_imm    = 3'h2
  } mode_t;

  typedef enum logic [2:0] {
    st_reset,
    st_fetch,
    st_eval,
    st_exception,
    st_halt
  } state_t;

  typedef enum logic [3:0] {
    cls_nop, cls_cmp, cls_inc, cls_dec, cls_unary, cls_alu3, cls_branch,
    cls_ldiu, cls_lda, cls_jmp, cls_load, cls_store, cls_illegal
  } op_class_t;

  typedef enum logic [1:0] {size_long, size_half, size_byte} access_size_t;

  typedef enum logic [2:0] {alu_add = 3'h2, alu_sub = 3'h3} alu_func_t;
  typedef enum logic [2:0] {alu2_reg = 3'h0, alu2_ind = 3'h1, alu2_one = 3'h2} alu2sel_t;

  typedef enum logic [3:0] {
    rs_alu   = 4'h0,
    rs_mdr   = 4'h1,
    rs_neg   = 4'h2,
    rs_com   = 4'h3,
    rs_mov   = 4'h4,
    rs_imm16 = 4'h6,
    rs_extb  = 4'h9,
    rs_exth  = 4'ha
  } regsel_t;

  typedef enum logic [2:0] {mdr_hold = 3'h0, mdr_bus = 3'h1, mdr_rega = 3'h3} mdrsel_t;
  typedef enum logic [1:0] {mar_hold = 2'h0, mar_bus = 2'h1, mar_alu = 2'h2} marsel_t;

  typedef enum logic [2:0] {
    pc_hold      = 3'h0,
    pc_inc       = 3'h1,
    pc_from_mar  = 3'h2,
    pc_relbranch = 3'h3,
    pc_from_alu  = 3'h4,
    pc_vector    = 3'h5
  } pcsel_t;

  localparam logic [2:0] alu1_reg = 3'h0;  // register port 1 into alu
  localparam logic addr_pc  = 1'b0;
  localparam logic addr_mar = 1'b1;

  // register mode opcodes
  localparam opcode_t op_nop  = 8'h50;
  localparam opcode_t op_cmp  = 8'h02;
  localparam opcode_t op_inc  = 8'h03;
  localparam opcode_t op_dec  = 8'h04;
  localparam opcode_t op_mov  = 8'h07;
  localparam opcode_t op_com  = 8'h08;
  localparam opcode_t op_neg  = 8'h09;
  localparam opcode_t op_extb = 8'h17;
  localparam opcode_t op_exth = 8'h18;
  localparam logic [3:0] op_alu3_hi = 4'h2;  // 0x2X group, func in low bits

  // immediate mode opcodes
  localparam opcode_t op_branch_last = 8'h0b;  // 0x00 up to here are branches
  localparam opcode_t op_ldiu        = 8'h0d;

  // register indirect low nibble, high nibble is don't care
  localparam logic [3:0] ind_st_l = 4'h0;
  localparam logic [3:0] ind_ld_l = 4'h1;
  localparam logic [3:0] ind_st_h = 4'h2;
  localparam logic [3:0] ind_ld_h = 4'h3;
  localparam logic [3:0] ind_st_b = 4'h4;
  localparam logic [3:0] ind_ld_b = 4'h5;
  localparam logic [3:0] ind_lda  = 4'ha;
  localparam logic [3:0] ind_jmp  = 4'hb;

  localparam logic [3:0] cc_always = 4'h0;
  localparam logic [3:0] cc_eq     = 4'h1;
  localparam logic [3:0] cc_ne     = 4'h2;
  localparam logic [3:0] cc_gtu    = 4'h3;
  localparam logic [3:0] cc_gt     = 4'h4;
  localparam logic [3:0] cc_ge     = 4'h5;
  localparam logic [3:0] cc_le     = 4'h6;
  localparam logic [3:0] cc_lt     = 4'h7;
  localparam logic [3:0] cc_geu    = 4'h8;
  localparam logic [3:0] cc_ltu    = 4'h9;
  localparam logic [3:0] cc_leu    = 4'ha;
  localparam logic [3:0] cc_never  = 4'hb;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef struct packed {
    mode_t     mode;
    opcode_t   op;
    reg_addr_t ra;
    reg_addr_t rb;
    reg_addr_t rc;
  } ir_fields_t;

  typedef struct packed {
    op_class_t    cls;
    regsel_t      unary_sel;  // result select for the one cycle unary ops
    access_size_t size;
    logic [3:0]   cond;
  } decoded_t;

  typedef struct packed {
    reg_addr_t read_addr1;
    reg_addr_t read_addr2;
    reg_addr_t write_addr;
    logic      write;
  } reg_ports_t;

  typedef struct packed {
    alu_func_t  alu_func;
    logic [2:0] alu1sel;
    alu2sel_t   alu2sel;
    regsel_t    regsel;
    mdrsel_t    mdrsel;
    marsel_t    marsel;
    pcsel_t     pcsel;
    logic       addrsel;
    logic       ccr_write;
    logic       ir_write;
  } dp_ctl_t;

  typedef struct packed {
    logic   read;
    logic   write;
    lanes_t byteenable;
  } bus_ctl_t;

endpackage

// ==== ir_decoder.sv ====
module ir_decoder import ctl_pkg::*; (
  input  word_t      ir,
  output ir_fields_t fields,
  output decoded_t   decoded
);

  assign fields.mode = mode_t'(ir[31:29]);  // unlisted modes fall to illegal below
  assign fields.op   = ir[28:21];
  assign fields.ra   = ir[20:16];
  assign fields.rb   = ir[15:11];
  assign fields.rc   = ir[10:6];

  always_comb begin
    decoded.cls       = cls_illegal;
    decoded.unary_sel = rs_alu;
    decoded.size      = size_long;
    decoded.cond      = fields.op[3:0];  // branch code sits in the low nibble
    case (fields.mode)
      mode_reg: begin
        if (fields.op[7:4] == op_alu3_hi) begin
          decoded.cls = cls_alu3;
        end else begin
          case (fields.op)
            op_nop: decoded.cls = cls_nop;
            op_cmp: decoded.cls = cls_cmp;
            op_inc: decoded.cls = cls_inc;
            op_dec: decoded.cls = cls_dec;
            op_mov: begin
              decoded.cls       = cls_unary;
              decoded.unary_sel = rs_mov;
            end
            op_com: begin
              decoded.cls       = cls_unary;
              decoded.unary_sel = rs_com;
            end
            op_neg: begin
              decoded.cls       = cls_unary;
              decoded.unary_sel = rs_neg;
            end
            op_extb: begin
              decoded.cls       = cls_unary;
              decoded.unary_sel = rs_extb;
            end
            op_exth: begin
              decoded.cls       = cls_unary;
              decoded.unary_sel = rs_exth;
            end
            default: decoded.cls = cls_illegal;
          endcase
        end
      end
      mode_imm: begin
        if (fields.op <= op_branch_last) begin
          decoded.cls = cls_branch;
        end else if (fields.op == op_ldiu) begin
          decoded.cls = cls_ldiu;
        end
      end
      mode_regind: begin
        case (fields.op[3:0])
          ind_st_l: decoded.cls = cls_store;
          ind_ld_l: decoded.cls = cls_load;
          ind_st_h: begin
            decoded.cls  = cls_store;
            decoded.size = size_half;
          end
          ind_ld_h: begin
            decoded.cls  = cls_load;
            decoded.size = size_half;
          end
          ind_st_b: begin
            decoded.cls  = cls_store;
            decoded.size = size_byte;
          end
          ind_ld_b: begin
            decoded.cls  = cls_load;
            decoded.size = size_byte;
          end
          ind_lda: decoded.cls = cls_lda;
          ind_jmp: decoded.cls = cls_jmp;
          default: decoded.cls = cls_illegal;
        endcase
      end
      default: decoded.cls = cls_illegal;  // direct mode no longer supported
    endcase
  end

endmodule

// ==== micro_sequencer.sv ====
module micro_sequencer import ctl_pkg::*; (
  input  logic       clock,
  input  logic       reset_n,
  input  ir_fields_t fields,
  input  decoded_t   decoded,
  input  logic       taken,
  input  lanes_t     lanes,
  input  logic       bus_wait,    // stretches the current bus step
  input  logic       busfault,
  output dp_ctl_t    dp,
  output reg_ports_t regs,
  output bus_ctl_t   bus,
  output logic       halt
);

  state_t state;
  state_t state_next;
  seq_t   seq;
  seq_t   seq_next;
  logic   fault_q;
  logic   fault_next;
  logic   is_store;

  assign is_store = (decoded.cls == cls_store);
  assign halt     = (state == st_halt);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state   <= st_reset;
      seq     <= '0;
      fault_q <= 1'b0;
    end else begin
      state   <= state_next;
      seq     <= seq_next;
      fault_q <= fault_next;
    end
  end

  always_comb begin
    state_next      = state;
    seq_next        = seq;
    fault_next      = fault_q;
    dp.alu_func     = alu_add;
    dp.alu1sel      = alu1_reg;
    dp.alu2sel      = alu2_reg;
    dp.regsel       = rs_alu;
    dp.mdrsel       = mdr_hold;
    dp.marsel       = mar_hold;
    dp.pcsel        = pc_hold;
    dp.addrsel      = addr_pc;
    dp.ccr_write    = 1'b0;
    dp.ir_write     = 1'b0;
    regs.read_addr1 = fields.ra;
    regs.read_addr2 = fields.rb;
    regs.write_addr = fields.ra;
    regs.write      = 1'b0;
    bus.read        = 1'b0;
    bus.write       = 1'b0;
    bus.byteenable  = 4'b1111;

    case (state)
      st_reset: begin
        case (seq)
          3'h0: begin
            dp.pcsel = pc_vector;  // point pc at the reset vector
            bus.read = 1'b1;
            if (busfault) begin
              state_next = st_exception;
              fault_next = 1'b1;
            end else if (!bus_wait) begin
              seq_next = 3'h1;
            end
          end
          3'h1: begin
            bus.read  = 1'b1;
            dp.marsel = mar_bus;  // mar <= vector contents
            seq_next  = 3'h2;
          end
          3'h2: begin
            dp.pcsel   = pc_from_mar;
            seq_next   = 3'h0;
            state_next = st_fetch;
          end
          default: state_next = st_halt;
        endcase
      end

      st_fetch: begin
        case (seq)
          3'h0: begin
            bus.read = 1'b1;
            if (busfault) begin
              state_next = st_exception;
              fault_next = 1'b1;
            end else if (!bus_wait) begin
              seq_next = 3'h1;
            end
          end
          3'h1: begin
            bus.read    = 1'b1;  // hold the bus while ir latches
            dp.ir_write = 1'b1;
            seq_next    = 3'h2;
          end
          3'h2: begin
            dp.pcsel   = pc_inc;
            seq_next   = 3'h0;
            state_next = st_eval;
          end
          default: state_next = st_halt;
        endcase
      end

      st_eval: begin
        case (decoded.cls)
          cls_nop: state_next = st_fetch;
          cls_cmp: begin
            dp.alu_func  = alu_sub;
            dp.ccr_write = 1'b1;
            state_next   = st_fetch;
          end
          cls_inc, cls_dec: begin
            if (seq == 3'h0) begin
              dp.alu2sel = alu2_one;  // ra +/- 1
              if (decoded.cls == cls_dec) begin
                dp.alu_func = alu_sub;
              end
              seq_next = 3'h1;
            end else begin
              regs.write = 1'b1;
              seq_next   = 3'h0;
              state_next = st_fetch;
            end
          end
          cls_unary: begin
            dp.regsel  = decoded.unary_sel;
            regs.write = 1'b1;
            state_next = st_fetch;
          end
          cls_alu3: begin
            dp.alu_func     = alu_func_t'(fields.op[2:0]);
            regs.read_addr1 = fields.rb;
            regs.read_addr2 = fields.rc;
            if (seq == 3'h0) begin
              seq_next = 3'h1;  // let the alu settle
            end else begin
              regs.write = 1'b1;
              seq_next   = 3'h0;
              state_next = st_fetch;
            end
          end
          cls_branch: begin
            dp.pcsel   = taken ? pc_relbranch : pc_hold;
            state_next = st_fetch;
          end
          cls_ldiu: begin
            dp.regsel  = rs_imm16;
            regs.write = 1'b1;
            state_next = st_fetch;
          end
          cls_lda, cls_jmp: begin
            if (seq == 3'h0) begin
              regs.read_addr1 = fields.rb;
              dp.alu2sel      = alu2_ind;  // rb + displacement
              seq_next        = 3'h1;
            end else begin
              if (decoded.cls == cls_jmp) begin
                dp.pcsel = pc_from_alu;
              end else begin
                regs.write = 1'b1;
              end
              seq_next   = 3'h0;
              state_next = st_fetch;
            end
          end
          cls_load, cls_store: begin
            dp.addrsel = addr_mar;
            case (seq)
              3'h0: begin
                regs.read_addr1 = fields.rb;
                dp.alu2sel      = alu2_ind;
                seq_next        = 3'h1;
              end
              3'h1: begin
                dp.marsel = mar_alu;
                if (is_store) begin
                  dp.mdrsel = mdr_rega;  // store data from ra
                end
                seq_next = 3'h2;
              end
              3'h2: begin
                if (is_store) begin
                  bus.write = 1'b1;
                end else begin
                  bus.read  = 1'b1;
                  dp.mdrsel = mdr_bus;
                end
                if (decoded.size != size_long) begin
                  bus.byteenable = lanes;
                end
                if (busfault) begin
                  state_next = st_exception;
                  fault_next = 1'b1;
                end else if (!bus_wait) begin
                  seq_next = 3'h3;
                end
              end
              3'h3: begin
                if (!is_store) begin
                  dp.regsel  = rs_mdr;
                  regs.write = 1'b1;
                end
                seq_next   = 3'h0;
                state_next = st_fetch;
              end
              default: state_next = st_halt;
            endcase
          end
          default: state_next = st_halt;  // undefined instruction
        endcase
      end

      st_exception: begin
        // leave the handler address in pc for inspection after halt
        if (fault_q) begin
          dp.pcsel = pc_vector;
        end
        state_next = st_halt;
      end

      st_halt: state_next = st_halt;
      default: state_next = st_halt;
    endcase
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_control \
  --Mdir obj_dir -o tb_control
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_control)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

// ==== src.f ====
ctl_pkg.sv
ir_decoder.sv
branch_cond.sv
byte_lane_gen.sv
micro_sequencer.sv
control.sv
control_properties.sv
tb_control.sv

// ==== tb_control.sv ====
module tb_control import ctl_pkg::*; ();

  logic       clock;
  logic       reset_n;
  word_t      ir;
  ccr_t       ccr;
  logic       bus_wait;
  logic       busfault;
  logic [1:0] bus_align;
  dp_ctl_t    dp;
  reg_ports_t regs;
  bus_ctl_t   bus;
  logic       halt;

  // one golden entry per scenario line
  word_t      g_ir     [64];
  ccr_t       g_ccr    [64];
  logic [1:0] g_align  [64];
  int         g_wait   [64];
  logic       g_fault  [64];
  int         g_wr     [64];
  logic [2:0] g_pcsel  [64];
  lanes_t     g_be     [64];
  logic       g_ccrw   [64];
  logic       g_halt   [64];
  int         g_cycles [64];
  int         n_lines;
  logic       loaded;
  int         errors;
  int         failed;

  control dut (
    .clock     (clock),
    .reset_n   (reset_n),
    .ir        (ir),
    .ccr       (ccr),
    .bus_wait  (bus_wait),
    .busfault  (busfault),
    .bus_align (bus_align),
    .dp        (dp),
    .regs      (regs),
    .bus       (bus),
    .halt      (halt)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic flag_error(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    errors++;
  endtask

  // state-only outputs are settled one unit after the rising edge
  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  function automatic logic is_fetch_read();
    return bus.read && !dp.ir_write && dp.addrsel == addr_pc &&
           dp.marsel == mar_hold && dp.pcsel == pc_hold;
  endfunction

  task automatic read_golden();
    int          fd;
    int          code;
    string       line;
    logic [31:0] f [11];
    n_lines = 0;
    fd = $fopen("control_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open control_golden.txt");
    end else begin
      while (!$feof(fd) && n_lines < 64) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin  // skip # lines
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                         f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
          if (code == 11) begin
            g_ir[n_lines]     = f[0];
            g_ccr[n_lines]    = f[1][3:0];
            g_align[n_lines]  = f[2][1:0];
            g_wait[n_lines]   = f[3];
            g_fault[n_lines]  = f[4][0];
            g_wr[n_lines]     = f[5];
            g_pcsel[n_lines]  = f[6][2:0];
            g_be[n_lines]     = f[7][3:0];
            g_ccrw[n_lines]   = f[8][0];
            g_halt[n_lines]   = f[9][0];
            g_cycles[n_lines] = f[10];
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // leaves the run at +1 of the first fetch cycle
  task automatic run_reset();
    int   w;
    int   k;
    logic done;
    w = $urandom_range(3, 0);
    k = 0;
    done = 1'b0;
    reset_n = 1'b0;
    bus_wait = 1'b0;
    busfault = 1'b0;
    repeat (16) @(posedge clock);
    #1;
    if (!(bus.read && dp.pcsel == pc_vector) || regs.write || bus.write || halt)
      flag_error("wrong outputs while reset is held");
    reset_n = 1'b1;
    while (!done) begin
      if (k > 0) tick();
      if (k == w + 3) begin
        if (!is_fetch_read()) flag_error("fetch did not start 3+w cycles after reset");
        done = 1'b1;
      end else begin
        bus_wait = (k < w);
        #1;
        if (regs.write || bus.write || dp.ir_write || halt)
          flag_error("write or halt active in reset sequence");
        if (k <= w && !(bus.read && dp.pcsel == pc_vector))
          flag_error("vector read step missing");
        if (k == w + 1 && !(bus.read && dp.marsel == mar_bus))
          flag_error("mar load from vector missing");
        if (k == w + 2 && dp.pcsel != pc_from_mar)
          flag_error("pc load from mar missing");
        k++;
      end
    end
    bus_wait = 1'b0;
  endtask

  task automatic do_fetch(input word_t instr);
    int   fw;
    int   n;
    logic got;
    fw = $urandom_range(3, 0);  // unscripted wait cycles
    n = 0;
    got = 1'b0;
    while (!got && n < 16) begin
      if (n > 0) tick();
      n++;
      if (dp.ir_write) begin
        ir = instr;
        bus_wait = 1'b0;
        got = 1'b1;
      end else begin
        if (!is_fetch_read()) flag_error("fetch read step expected");
        bus_wait = (n <= fw);
      end
      #1;
    end
    if (!got) flag_error("no ir_write during fetch");
    tick();
    n++;
    #1;
    if (dp.pcsel != pc_inc) flag_error("pc increment step missing after ir_write");
    if (n != 3 + fw) flag_error($sformatf("fetch took %0d cycles, expected %0d", n, 3 + fw));
  endtask

  task automatic run_eval(input int idx, output int n, output int wr, output pcsel_t pcs,
                          output lanes_t be, output logic ccrw, output logic rd,
                          output logic wt, output regsel_t wsel);
    int   bw;
    logic bus_step;
    logic stop;
    n = 0;
    wr = 0;
    pcs = pc_hold;
    be = 4'hf;
    ccrw = 1'b0;
    rd = 1'b0;
    wt = 1'b0;
    wsel = rs_alu;
    bw = 0;
    stop = 1'b0;
    while (!stop && n < 30) begin
      tick();
      if (halt || is_fetch_read()) begin
        stop = 1'b1;
      end else begin
        n++;
        bus_step = bus.read || bus.write;
        busfault = g_fault[idx] && bus_step;
        bus_wait = bus_step && (bw < g_wait[idx]);
        if (bus_step) bw++;
        #1;
        if (regs.write) begin
          wr++;
          wsel = dp.regsel;
        end
        if (dp.ccr_write) ccrw = 1'b1;
        if (dp.pcsel != pc_hold) pcs = dp.pcsel;
        if (bus_step) begin
          be = bus.byteenable;
          if (bus.read) rd = 1'b1;
          if (bus.write) wt = 1'b1;
        end
        if (dp.ir_write) flag_error("ir_write during evaluation");
      end
    end
    if (!stop) flag_error("evaluation did not end");
    busfault = 1'b0;
    bus_wait = 1'b0;
  endtask

  task automatic check_halt_holds();
    int k;
    for (k = 0; k < 5; k++) begin
      if (!halt) flag_error("halt dropped before reset");
      if (dp.ir_write || bus.read || bus.write) flag_error("bus or ir activity after halt");
      tick();
    end
  endtask

  initial begin
    int      i;
    int      e0;
    int      n;
    int      wr;
    pcsel_t  pcs;
    lanes_t  be;
    logic    ccrw;
    logic    rd;
    logic    wt;
    regsel_t wsel;
    void'($urandom(42));
    reset_n = 1'b0;
    ir = '0;
    ccr = '0;
    bus_wait = 1'b0;
    busfault = 1'b0;
    bus_align = 2'b00;
    errors = 0;
    failed = 0;
    loaded = 1'b0;
    read_golden();
    loaded = 1'b1;
    if (n_lines > 0) run_reset();
    for (i = 0; i < n_lines; i++) begin
      e0 = errors;
      ccr = g_ccr[i];
      bus_align = g_align[i];
      do_fetch(g_ir[i]);
      run_eval(i, n, wr, pcs, be, ccrw, rd, wt, wsel);
      if (n != g_cycles[i])
        flag_error($sformatf("evaluation took %0d cycles, expected %0d", n, g_cycles[i]));
      if (wr != g_wr[i])
        flag_error($sformatf("%0d register writes, expected %0d", wr, g_wr[i]));
      if (pcs != g_pcsel[i])
        flag_error($sformatf("pcsel %0d, expected %0d", pcs, g_pcsel[i]));
      if (be != g_be[i])
        flag_error($sformatf("byteenable %h, expected %h", be, g_be[i]));
      if (ccrw != g_ccrw[i])
        flag_error($sformatf("ccr_write %0b, expected %0b", ccrw, g_ccrw[i]));
      if (halt != g_halt[i])
        flag_error($sformatf("halt %0b, expected %0b", halt, g_halt[i]));
      if (!g_fault[i] && g_cycles[i] == 4 + g_wait[i]) begin  // load or store, 4 + w cycles
        if (g_wr[i] > 0 && !(rd && !wt && wsel == rs_mdr))
          flag_error("load without a bus read and an mdr write-back");
        if (g_wr[i] == 0 && !(wt && !rd))
          flag_error("store without a bus write");
      end else if (!g_fault[i] && (rd || wt || (wr > 0 && wsel == rs_mdr))) begin
        flag_error("bus access or mdr write-back outside a load or store");
      end
      if (halt) begin
        check_halt_holds();
        run_reset();  // only a reset leaves halt
      end
      if (errors != e0) failed++;
      $display("test %0d ir %h: %s", i, g_ir[i], (errors == e0) ? "ok" : "mismatch");
    end
    $display("tests %0d, failed %0d, errors %0d", n_lines, failed, errors);
    if (errors == 0 && n_lines > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    repeat (n_lines * 40 + 16 * (n_lines + 1)) @(posedge clock);
    $display("watchdog expired, the run did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule
